/* rtl/mem_pkg.sv */
// bus widths, AXI4-Lite response codes, ebreak encoding and channel payload structs
`default_nettype none

package mem_pkg;

	// address and data bus width
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// one strobe bit per data byte
	localparam int STRB_W = DATA_W / 8;

	// AXI response codes
	// only OKAY and SLVERR are ever produced by the slave
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// ebreak: SYSTEM opcode, funct12 = 1
	// matched as a whole word, no field decode
	localparam logic [DATA_W-1:0] EBREAK_INST = 32'h0010_0073;

	// read address channel
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} axi_ar_t;

	// read data channel
	typedef struct packed {
		logic [DATA_W-1:0] data;
		resp_e             resp;
	} axi_r_t;

	// write address channel
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} axi_aw_t;

	// write data channel
	// strb[i] enables byte lane i
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axi_w_t;

	// write response channel
	typedef struct packed {
		resp_e resp;
	} axi_b_t;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
// instruction fetch unit: pc register, AXI4-Lite instruction reads, ebreak and bus error stop
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
	parameter logic [mem_pkg::ADDR_W-1:0] RESET_PC = '0
) (
	input  wire                          clk,
	input  wire                          rst_n_i,
	input  wire                          fetch_en_i,
	// read address channel
	output mem_pkg::axi_ar_t             ar_o,
	output logic                         ar_valid_o,
	input  wire                          ar_ready_i,
	// read data channel
	input  wire mem_pkg::axi_r_t         r_i,
	input  wire                          r_valid_i,
	output logic                         r_ready_o,
	// fetched instruction
	output logic [mem_pkg::DATA_W-1:0]   inst_o,
	output logic                         inst_valid_o,
	output logic [mem_pkg::ADDR_W-1:0]   pc_o,
	// sticky stop flags
	output logic                         finish_o,
	output logic                         invalid_o
);

	localparam logic [mem_pkg::ADDR_W-1:0] PC_STEP = 4;

	// request: ar may be up, wait: ar done, expecting r
	typedef enum logic {
		S_REQ,
		S_WAIT
	} state_e;

	state_e                     state_q;
	logic [mem_pkg::ADDR_W-1:0] pc_q;
	logic                       ar_valid_q;
	logic                       run;
	logic                       r_fire;
	logic                       r_err;
	logic                       r_ebreak;

	// fetch allowed only while enabled and not stopped
	assign run      = fetch_en_i & ~finish_o & ~invalid_o;
	// r_ready is held high in wait, so valid alone completes it
	assign r_fire   = (state_q == S_WAIT) & r_valid_i;
	assign r_err    = r_i.resp == mem_pkg::RESP_SLVERR;
	assign r_ebreak = r_i.data == mem_pkg::EBREAK_INST;

	assign ar_o.addr  = pc_q;
	assign ar_valid_o = ar_valid_q;
	assign r_ready_o  = state_q == S_WAIT;

	// control state
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q      <= S_REQ;
			pc_q         <= RESET_PC;
			ar_valid_q   <= 1'b0;
			inst_valid_o <= 1'b0;
			finish_o     <= 1'b0;
			invalid_o    <= 1'b0;
		end else begin
			// single cycle pulse
			inst_valid_o <= 1'b0;
			case (state_q)
				S_REQ: begin
					if (ar_valid_q && ar_ready_i) begin
						ar_valid_q <= 1'b0;
						state_q    <= S_WAIT;
					end else if (!ar_valid_q && run) begin
						ar_valid_q <= 1'b1;
					end
				end
				S_WAIT: begin
					if (r_fire) begin
						state_q <= S_REQ;
						pc_q    <= pc_q + PC_STEP;
						// error response is not an instruction, no pulse
						if (r_err) begin
							invalid_o <= 1'b1;
						end else begin
							inst_valid_o <= 1'b1;
							if (r_ebreak) begin
								finish_o <= 1'b1;
							end
						end
						// next read right away unless this word stops fetch
						ar_valid_q <= fetch_en_i & ~r_err & ~r_ebreak;
					end
				end
				default: state_q <= S_REQ;
			endcase
		end
	end

	// returned word and the pc it came from
	always_ff @(posedge clk) begin
		if (r_fire && !r_err) begin
			inst_o <= r_i.data;
			pc_o   <= pc_q;
		end
	end

endmodule

`default_nettype wire

/* rtl/axi_arbiter.sv */
// two-master to one-slave AXI4-Lite arbiter, fetch reads vs data reads/writes, alternating priority
`timescale 1ns/10ps
`default_nettype none

module axi_arbiter (
	input  wire                    clk,
	input  wire                    rst_n_i,
	// master 0, fetch unit
	input  wire mem_pkg::axi_ar_t  if_ar_i,
	input  wire                    if_ar_valid_i,
	output logic                   if_ar_ready_o,
	output mem_pkg::axi_r_t        if_r_o,
	output logic                   if_r_valid_o,
	input  wire                    if_r_ready_i,
	// master 1, external data port
	input  wire mem_pkg::axi_ar_t  dm_ar_i,
	input  wire                    dm_ar_valid_i,
	output logic                   dm_ar_ready_o,
	output mem_pkg::axi_r_t        dm_r_o,
	output logic                   dm_r_valid_o,
	input  wire                    dm_r_ready_i,
	input  wire mem_pkg::axi_aw_t  dm_aw_i,
	input  wire                    dm_aw_valid_i,
	output logic                   dm_aw_ready_o,
	input  wire mem_pkg::axi_w_t   dm_w_i,
	input  wire                    dm_w_valid_i,
	output logic                   dm_w_ready_o,
	output mem_pkg::axi_b_t        dm_b_o,
	output logic                   dm_b_valid_o,
	input  wire                    dm_b_ready_i,
	// slave side
	output mem_pkg::axi_ar_t       sl_ar_o,
	output logic                   sl_ar_valid_o,
	input  wire                    sl_ar_ready_i,
	input  wire mem_pkg::axi_r_t   sl_r_i,
	input  wire                    sl_r_valid_i,
	output logic                   sl_r_ready_o,
	output mem_pkg::axi_aw_t       sl_aw_o,
	output logic                   sl_aw_valid_o,
	input  wire                    sl_aw_ready_i,
	output mem_pkg::axi_w_t        sl_w_o,
	output logic                   sl_w_valid_o,
	input  wire                    sl_w_ready_i,
	input  wire mem_pkg::axi_b_t   sl_b_i,
	input  wire                    sl_b_valid_i,
	output logic                   sl_b_ready_o
);

	// who owns the slave port
	typedef enum logic [1:0] {
		G_IDLE,
		G_INST,
		G_DRD,
		G_DWR
	} grant_e;

	grant_e gnt_q;
	// set when the fetch read won the last grant
	logic   last_inst_q;
	logic   gnt_inst;
	logic   gnt_drd;
	logic   gnt_dwr;
	logic   dm_wr_req;
	logic   dm_req;
	logic   pick_inst;
	logic   done;

	assign gnt_inst = gnt_q == G_INST;
	assign gnt_drd  = gnt_q == G_DRD;
	assign gnt_dwr  = gnt_q == G_DWR;

	// a write counts only with aw and w both presented
	assign dm_wr_req = dm_aw_valid_i & dm_w_valid_i;
	assign dm_req    = dm_wr_req | dm_ar_valid_i;
	// fetch wins if alone, or if data won last time
	assign pick_inst = if_ar_valid_i & (~dm_req | ~last_inst_q);

	// transaction ends on the R or B handshake of the winner
	assign done = (gnt_inst & sl_r_valid_i & if_r_ready_i)
		| (gnt_drd & sl_r_valid_i & dm_r_ready_i)
		| (gnt_dwr & sl_b_valid_i & dm_b_ready_i);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			gnt_q       <= G_IDLE;
			last_inst_q <= 1'b0;
		end else begin
			case (gnt_q)
				G_IDLE: begin
					if (pick_inst) begin
						gnt_q       <= G_INST;
						last_inst_q <= 1'b1;
					end else if (dm_wr_req) begin
						// write before read on the data side
						gnt_q       <= G_DWR;
						last_inst_q <= 1'b0;
					end else if (dm_ar_valid_i) begin
						gnt_q       <= G_DRD;
						last_inst_q <= 1'b0;
					end
				end
				default: begin
					// grant held through any R/B back-pressure
					if (done) begin
						gnt_q <= G_IDLE;
					end
				end
			endcase
		end
	end

	// winner's request channels toward the slave
	assign sl_ar_o       = gnt_inst ? if_ar_i : dm_ar_i;
	assign sl_ar_valid_o = (gnt_inst & if_ar_valid_i) | (gnt_drd & dm_ar_valid_i);
	assign sl_r_ready_o  = (gnt_inst & if_r_ready_i) | (gnt_drd & dm_r_ready_i);
	// only master 1 writes
	assign sl_aw_o       = dm_aw_i;
	assign sl_aw_valid_o = gnt_dwr & dm_aw_valid_i;
	assign sl_w_o        = dm_w_i;
	assign sl_w_valid_o  = gnt_dwr & dm_w_valid_i;
	assign sl_b_ready_o  = gnt_dwr & dm_b_ready_i;

	// readies and responses back to the winner only
	assign if_ar_ready_o = gnt_inst & sl_ar_ready_i;
	assign if_r_o        = sl_r_i;
	assign if_r_valid_o  = gnt_inst & sl_r_valid_i;

	assign dm_ar_ready_o = gnt_drd & sl_ar_ready_i;
	assign dm_r_o        = sl_r_i;
	assign dm_r_valid_o  = gnt_drd & sl_r_valid_i;
	assign dm_aw_ready_o = gnt_dwr & sl_aw_ready_i;
	assign dm_w_ready_o  = gnt_dwr & sl_w_ready_i;
	assign dm_b_o        = sl_b_i;
	assign dm_b_valid_o  = gnt_dwr & sl_b_valid_i;

endmodule

`default_nettype wire

/* rtl/axi_sram.sv */
// AXI4-Lite SRAM slave: word array, byte strobes, range check, registered R and B responses
`timescale 1ns/10ps
`default_nettype none

module axi_sram #(
	parameter int MEM_WORDS = 256
) (
	input  wire                    clk,
	input  wire                    rst_n_i,
	// read address
	input  wire mem_pkg::axi_ar_t  ar_i,
	input  wire                    ar_valid_i,
	output logic                   ar_ready_o,
	// read data
	output mem_pkg::axi_r_t        r_o,
	output logic                   r_valid_o,
	input  wire                    r_ready_i,
	// write address
	input  wire mem_pkg::axi_aw_t  aw_i,
	input  wire                    aw_valid_i,
	output logic                   aw_ready_o,
	// write data
	input  wire mem_pkg::axi_w_t   w_i,
	input  wire                    w_valid_i,
	output logic                   w_ready_o,
	// write response
	output mem_pkg::axi_b_t        b_o,
	output logic                   b_valid_o,
	input  wire                    b_ready_i
);

	// array index width, at least one bit
	localparam int IDX_W  = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	// word address, byte offset dropped
	localparam int WIDX_W = mem_pkg::ADDR_W - 2;

	logic [mem_pkg::DATA_W-1:0] mem_q [MEM_WORDS];
	mem_pkg::axi_r_t            r_q;
	mem_pkg::axi_b_t            b_q;
	logic                       r_valid_q;
	logic                       b_valid_q;
	logic                       idle;
	logic                       ar_fire;
	logic                       wr_fire;
	logic [WIDX_W-1:0]          rd_word;
	logic [WIDX_W-1:0]          wr_word;
	logic                       rd_ok;
	logic                       wr_ok;
	logic [IDX_W-1:0]           rd_idx;
	logic [IDX_W-1:0]           wr_idx;

	// busy while any response is still pending
	assign idle    = ~r_valid_q & ~b_valid_q;
	assign ar_fire = idle & ar_valid_i;
	// aw and w accepted together, never one alone
	assign wr_fire = idle & aw_valid_i & w_valid_i;

	assign ar_ready_o = idle;
	assign aw_ready_o = wr_fire;
	assign w_ready_o  = wr_fire;

	// range check on the full word index
	assign rd_word = ar_i.addr[mem_pkg::ADDR_W-1:2];
	assign wr_word = aw_i.addr[mem_pkg::ADDR_W-1:2];
	assign rd_ok   = rd_word < WIDX_W'(MEM_WORDS);
	assign wr_ok   = wr_word < WIDX_W'(MEM_WORDS);
	// low bits index the array, only used when in range
	assign rd_idx  = rd_word[IDX_W-1:0];
	assign wr_idx  = wr_word[IDX_W-1:0];

	assign r_o       = r_q;
	assign r_valid_o = r_valid_q;
	assign b_o       = b_q;
	assign b_valid_o = b_valid_q;

	// response valids, held until the master takes them
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (ar_fire) begin
				r_valid_q <= 1'b1;
			end else if (r_ready_i) begin
				r_valid_q <= 1'b0;
			end
			if (wr_fire) begin
				b_valid_q <= 1'b1;
			end else if (b_ready_i) begin
				b_valid_q <= 1'b0;
			end
		end
	end

	// response payloads
	// out of range reads return zero with SLVERR
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			r_q.data <= rd_ok ? mem_q[rd_idx] : '0;
			r_q.resp <= rd_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
		end
		if (wr_fire) begin
			b_q.resp <= wr_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
		end
	end

	// strobe merged write, out of range writes dropped
	always_ff @(posedge clk) begin
		if (wr_fire && wr_ok) begin
			for (int b = 0; b < mem_pkg::STRB_W; b++) begin
				if (w_i.strb[b]) begin
					mem_q[wr_idx][8*b +: 8] <= w_i.data[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/core_top.sv */
// memory side top level: fetch unit and external data master sharing one AXI4-Lite SRAM
`timescale 1ns/10ps
`default_nettype none

module core_top #(
	parameter int                         MEM_WORDS = 256,
	parameter logic [mem_pkg::ADDR_W-1:0] RESET_PC  = '0
) (
	input  wire                          clk,
	input  wire                          rst_n_i,
	input  wire                          fetch_en_i,
	// data master port, driven from outside
	input  wire mem_pkg::axi_ar_t        dm_ar_i,
	input  wire                          dm_ar_valid_i,
	output wire                          dm_ar_ready_o,
	output wire mem_pkg::axi_r_t         dm_r_o,
	output wire                          dm_r_valid_o,
	input  wire                          dm_r_ready_i,
	input  wire mem_pkg::axi_aw_t        dm_aw_i,
	input  wire                          dm_aw_valid_i,
	output wire                          dm_aw_ready_o,
	input  wire mem_pkg::axi_w_t         dm_w_i,
	input  wire                          dm_w_valid_i,
	output wire                          dm_w_ready_o,
	output wire mem_pkg::axi_b_t         dm_b_o,
	output wire                          dm_b_valid_o,
	input  wire                          dm_b_ready_i,
	// fetch results and status
	output wire [mem_pkg::DATA_W-1:0]    inst_o,
	output wire                          inst_valid_o,
	output wire [mem_pkg::ADDR_W-1:0]    pc_o,
	output wire                          finish_o,
	output wire                          invalid_o
);

	// fetch unit to arbiter
	wire mem_pkg::axi_ar_t if_ar;
	wire                   if_ar_valid;
	wire                   if_ar_ready;
	wire mem_pkg::axi_r_t  if_r;
	wire                   if_r_valid;
	wire                   if_r_ready;

	// arbiter to sram
	wire mem_pkg::axi_ar_t sl_ar;
	wire                   sl_ar_valid;
	wire                   sl_ar_ready;
	wire mem_pkg::axi_r_t  sl_r;
	wire                   sl_r_valid;
	wire                   sl_r_ready;
	wire mem_pkg::axi_aw_t sl_aw;
	wire                   sl_aw_valid;
	wire                   sl_aw_ready;
	wire mem_pkg::axi_w_t  sl_w;
	wire                   sl_w_valid;
	wire                   sl_w_ready;
	wire mem_pkg::axi_b_t  sl_b;
	wire                   sl_b_valid;
	wire                   sl_b_ready;

	// master 0
	fetch_unit #(
		.RESET_PC (RESET_PC)
	) u_fetch_unit (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.fetch_en_i   (fetch_en_i),
		.ar_o         (if_ar),
		.ar_valid_o   (if_ar_valid),
		.ar_ready_i   (if_ar_ready),
		.r_i          (if_r),
		.r_valid_i    (if_r_valid),
		.r_ready_o    (if_r_ready),
		.inst_o       (inst_o),
		.inst_valid_o (inst_valid_o),
		.pc_o         (pc_o),
		.finish_o     (finish_o),
		.invalid_o    (invalid_o)
	);

	// fetch and data port onto one slave
	axi_arbiter u_axi_arbiter (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.if_ar_i       (if_ar),
		.if_ar_valid_i (if_ar_valid),
		.if_ar_ready_o (if_ar_ready),
		.if_r_o        (if_r),
		.if_r_valid_o  (if_r_valid),
		.if_r_ready_i  (if_r_ready),
		.dm_ar_i       (dm_ar_i),
		.dm_ar_valid_i (dm_ar_valid_i),
		.dm_ar_ready_o (dm_ar_ready_o),
		.dm_r_o        (dm_r_o),
		.dm_r_valid_o  (dm_r_valid_o),
		.dm_r_ready_i  (dm_r_ready_i),
		.dm_aw_i       (dm_aw_i),
		.dm_aw_valid_i (dm_aw_valid_i),
		.dm_aw_ready_o (dm_aw_ready_o),
		.dm_w_i        (dm_w_i),
		.dm_w_valid_i  (dm_w_valid_i),
		.dm_w_ready_o  (dm_w_ready_o),
		.dm_b_o        (dm_b_o),
		.dm_b_valid_o  (dm_b_valid_o),
		.dm_b_ready_i  (dm_b_ready_i),
		.sl_ar_o       (sl_ar),
		.sl_ar_valid_o (sl_ar_valid),
		.sl_ar_ready_i (sl_ar_ready),
		.sl_r_i        (sl_r),
		.sl_r_valid_i  (sl_r_valid),
		.sl_r_ready_o  (sl_r_ready),
		.sl_aw_o       (sl_aw),
		.sl_aw_valid_o (sl_aw_valid),
		.sl_aw_ready_i (sl_aw_ready),
		.sl_w_o        (sl_w),
		.sl_w_valid_o  (sl_w_valid),
		.sl_w_ready_i  (sl_w_ready),
		.sl_b_i        (sl_b),
		.sl_b_valid_i  (sl_b_valid),
		.sl_b_ready_o  (sl_b_ready)
	);

	// shared memory
	axi_sram #(
		.MEM_WORDS (MEM_WORDS)
	) u_axi_sram (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.ar_i       (sl_ar),
		.ar_valid_i (sl_ar_valid),
		.ar_ready_o (sl_ar_ready),
		.r_o        (sl_r),
		.r_valid_o  (sl_r_valid),
		.r_ready_i  (sl_r_ready),
		.aw_i       (sl_aw),
		.aw_valid_i (sl_aw_valid),
		.aw_ready_o (sl_aw_ready),
		.w_i        (sl_w),
		.w_valid_i  (sl_w_valid),
		.w_ready_o  (sl_w_ready),
		.b_o        (sl_b),
		.b_valid_o  (sl_b_valid),
		.b_ready_i  (sl_b_ready)
	);

endmodule

`default_nettype wire

/* testbench/core_top_chk.sv */
// bound assertions: request hold on AR/AW, one transaction at the slave, fetch stop flags
`timescale 1ns/10ps
`default_nettype none

module core_top_chk (
	input wire        clk,
	input wire        rst_n_i,
	input wire        ar_valid_i,
	input wire        ar_ready_i,
	input wire [31:0] ar_addr_i,
	input wire        aw_valid_i,
	input wire        aw_ready_i,
	input wire [31:0] aw_addr_i,
	input wire        r_valid_i,
	input wire        b_valid_i,
	input wire        finish_i,
	input wire        invalid_i
);

	// request held with its payload until ready
	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
		else $error("ar_valid dropped or address changed before ar_ready");

	a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i))
		else $error("aw_valid dropped or address changed before aw_ready");

	// one owner of the slave port at a time
	// no new request while a response is still pending
	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
		(ar_valid_i || aw_valid_i) |-> !(r_valid_i || b_valid_i))
		else $error("request presented while a response is still pending");

	// stop flags exclusive, and no read once stopped
	a_stop: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(finish_i && invalid_i) && ((finish_i || invalid_i) -> !ar_valid_i))
		else $error("fetch stop flags both set or read issued after stop");

endmodule

// slave side of the arbiter
bind axi_arbiter core_top_chk u_arb_chk (
	.clk        (clk),
	.rst_n_i    (rst_n_i),
	.ar_valid_i (sl_ar_valid_o),
	.ar_ready_i (sl_ar_ready_i),
	.ar_addr_i  (sl_ar_o.addr),
	.aw_valid_i (sl_aw_valid_o),
	.aw_ready_i (sl_aw_ready_i),
	.aw_addr_i  (sl_aw_o.addr),
	.r_valid_i  (sl_r_valid_i),
	.b_valid_i  (sl_b_valid_i),
	.finish_i   (1'b0),
	.invalid_i  (1'b0)
);

// fetch unit request and status
bind fetch_unit core_top_chk u_fetch_chk (
	.clk        (clk),
	.rst_n_i    (rst_n_i),
	.ar_valid_i (ar_valid_o),
	.ar_ready_i (ar_ready_i),
	.ar_addr_i  (ar_o.addr),
	.aw_valid_i (1'b0),
	.aw_ready_i (1'b0),
	.aw_addr_i  (32'h0),
	.r_valid_i  (r_valid_i),
	.b_valid_i  (1'b0),
	.finish_i   (finish_o),
	.invalid_i  (invalid_o)
);

`default_nettype wire

/* testbench/tb_core_top.sv */
// testbench for core_top: clock, reset, xorshift, compare tasks, directed tests, timeout
`timescale 1ns/10ps
`default_nettype none

module tb_core_top;

	localparam logic [31:0] RESET_PC = 32'h0;
	localparam int MEM_WORDS = 256;
	// whole run stays far below this
	localparam int CYCLE_LIMIT = 20000;

	logic clk;
	logic rst_n_i;
	logic fetch_en_i;
	mem_pkg::axi_ar_t dm_ar;
	logic dm_ar_valid;
	logic dm_r_ready;
	mem_pkg::axi_aw_t dm_aw;
	logic dm_aw_valid;
	mem_pkg::axi_w_t dm_w;
	logic dm_w_valid;
	logic dm_b_ready;
	wire dm_ar_ready;
	wire mem_pkg::axi_r_t dm_r;
	wire dm_r_valid;
	wire dm_aw_ready;
	wire dm_w_ready;
	wire mem_pkg::axi_b_t dm_b;
	wire dm_b_valid;
	wire [31:0] inst;
	wire inst_valid;
	wire [31:0] pc;
	wire finish;
	wire invalid;

	// expected memory contents
	logic [31:0] ref_mem [MEM_WORDS];
	// fetch stream as seen on inst_valid pulses
	logic [31:0] fetch_pc [$];
	logic [31:0] fetch_inst [$];
	logic [31:0] rng_state = 32'hdd89;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	core_top #(.MEM_WORDS(MEM_WORDS), .RESET_PC(RESET_PC)) uut (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.fetch_en_i(fetch_en_i),
		.dm_ar_i(dm_ar),
		.dm_ar_valid_i(dm_ar_valid),
		.dm_ar_ready_o(dm_ar_ready),
		.dm_r_o(dm_r),
		.dm_r_valid_o(dm_r_valid),
		.dm_r_ready_i(dm_r_ready),
		.dm_aw_i(dm_aw),
		.dm_aw_valid_i(dm_aw_valid),
		.dm_aw_ready_o(dm_aw_ready),
		.dm_w_i(dm_w),
		.dm_w_valid_i(dm_w_valid),
		.dm_w_ready_o(dm_w_ready),
		.dm_b_o(dm_b),
		.dm_b_valid_o(dm_b_valid),
		.dm_b_ready_i(dm_b_ready),
		.inst_o(inst),
		.inst_valid_o(inst_valid),
		.pc_o(pc),
		.finish_o(finish),
		.invalid_o(invalid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	// record every fetched word, pulse lasts one cycle
	always @(negedge clk) begin
		if (inst_valid === 1'b1) begin
			fetch_pc.push_back(pc);
			fetch_inst.push_back(inst);
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// random word that never stops fetch
	function automatic logic [31:0] random_inst();
		logic [31:0] w;
		w = next_random();
		if (w == mem_pkg::EBREAK_INST) begin
			w = w ^ 32'h1;
		end
		return w;
	endfunction

	function automatic logic [31:0] word_addr(input int idx);
		return 32'(idx) << 2;
	endfunction

	// byte lanes with strobe set take the new data
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] strb);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input mem_pkg::resp_e exp,
		input mem_pkg::resp_e act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected address %h, actual %h", name, exp, act);
		end
	endtask

	// called on a falling edge, returns on a falling edge with the port idle
	task automatic dm_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output mem_pkg::resp_e resp);
		dm_aw.addr = addr;
		dm_w.data = data;
		dm_w.strb = strb;
		dm_aw_valid = 1'b1;
		dm_w_valid = 1'b1;
		// ready seen here means the transfer happens on the next rising edge
		do @(negedge clk); while (dm_aw_ready !== 1'b1 && dm_w_ready !== 1'b1);
		if (dm_aw_ready !== dm_w_ready) begin
			errors++;
			$display("dm_write: aw_ready and w_ready not raised together at address %h", addr);
		end
		@(negedge clk);
		dm_aw_valid = 1'b0;
		dm_w_valid = 1'b0;
		// b_valid one cycle after the handshake
		while (dm_b_valid !== 1'b1) begin
			@(negedge clk);
		end
		resp = dm_b.resp;
		@(negedge clk);
	endtask

	task automatic dm_read(input logic [31:0] addr, output logic [31:0] data,
		output mem_pkg::resp_e resp);
		dm_ar.addr = addr;
		dm_ar_valid = 1'b1;
		do @(negedge clk); while (dm_ar_ready !== 1'b1);
		@(negedge clk);
		dm_ar_valid = 1'b0;
		while (dm_r_valid !== 1'b1) begin
			@(negedge clk);
		end
		data = dm_r.data;
		resp = dm_r.resp;
		@(negedge clk);
	endtask

	task automatic do_reset();
		fetch_en_i = 1'b0;
		rst_n_i = 1'b0;
		repeat (2) @(negedge clk);
		rst_n_i = 1'b1;
	endtask

	// n random words from word 0, optional ebreak right after
	task automatic load_program(input int n, input bit with_ebreak);
		mem_pkg::resp_e resp;
		for (int i = 0; i < n; i++) begin
			ref_mem[i] = random_inst();
			dm_write(word_addr(i), ref_mem[i], 4'hf, resp);
		end
		if (with_ebreak) begin
			ref_mem[n] = mem_pkg::EBREAK_INST;
			dm_write(word_addr(n), mem_pkg::EBREAK_INST, 4'hf, resp);
		end
	endtask

	task automatic start_fetch();
		fetch_pc.delete();
		fetch_inst.delete();
		fetch_en_i = 1'b1;
	endtask

	// until either stop flag, then a short quiet window
	task automatic wait_stop();
		do @(negedge clk); while (finish !== 1'b1 && invalid !== 1'b1);
		repeat (8) @(negedge clk);
		fetch_en_i = 1'b0;
	endtask

	task automatic check_fetch(input string name, input int n);
		if (fetch_pc.size() != n) begin
			errors++;
			$display("[FAIL] %s: expected %0d instructions, actual %0d", name, n, fetch_pc.size());
		end
		for (int i = 0; i < n && i < fetch_pc.size(); i++) begin
			check_addr(name, RESET_PC + word_addr(i), fetch_pc[i]);
			check_word(name, ref_mem[i], fetch_inst[i]);
		end
	endtask

	task automatic test_strobe_rw();
		logic [3:0] strbs [8];
		logic [31:0] w;
		mem_pkg::resp_e resp;
		strbs = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b0101, 4'b1010};
		for (int i = 0; i < 16; i++) begin
			ref_mem[i] = next_random();
			dm_write(word_addr(i), ref_mem[i], 4'hf, resp);
			check_resp("strobe_rw full write", mem_pkg::RESP_OKAY, resp);
		end
		// partial writes on the odd words
		for (int i = 0; i < 8; i++) begin
			w = next_random();
			dm_write(word_addr(2*i + 1), w, strbs[i], resp);
			check_resp("strobe_rw partial write", mem_pkg::RESP_OKAY, resp);
			ref_mem[2*i + 1] = merge_bytes(ref_mem[2*i + 1], w, strbs[i]);
		end
		for (int i = 0; i < 16; i++) begin
			dm_read(word_addr(i), w, resp);
			check_resp("strobe_rw read", mem_pkg::RESP_OKAY, resp);
			check_word("strobe_rw read", ref_mem[i], w);
		end
	endtask

	task automatic test_out_of_range();
		logic [31:0] w;
		mem_pkg::resp_e resp;
		dm_read(word_addr(MEM_WORDS), w, resp);
		check_resp("out_of_range read 256", mem_pkg::RESP_SLVERR, resp);
		check_word("out_of_range read 256", 32'h0, w);
		dm_read(word_addr(300), w, resp);
		check_resp("out_of_range read 300", mem_pkg::RESP_SLVERR, resp);
		check_word("out_of_range read 300", 32'h0, w);
		// word 256 aliases word 0 in the low index bits
		dm_write(word_addr(MEM_WORDS), next_random(), 4'hf, resp);
		check_resp("out_of_range write", mem_pkg::RESP_SLVERR, resp);
		dm_read(word_addr(0), w, resp);
		check_resp("out_of_range word 0", mem_pkg::RESP_OKAY, resp);
		check_word("out_of_range word 0", ref_mem[0], w);
	endtask

	task automatic test_fetch_finish();
		do_reset();
		load_program(16, 1'b1);
		start_fetch();
		wait_stop();
		check_fetch("fetch_finish", 17);
		if (finish !== 1'b1 || invalid !== 1'b0) begin
			errors++;
			$display("fetch_finish: finish not set or invalid set after ebreak");
		end
	endtask

	task automatic test_shared_access();
		logic [31:0] w;
		mem_pkg::resp_e resp;
		int n0;
		do_reset();
		load_program(96, 1'b1);
		start_fetch();
		n0 = fetch_pc.size();
		// data region 128 and up, away from the program
		for (int i = 0; i < 16; i++) begin
			ref_mem[128 + i] = next_random();
			dm_write(word_addr(128 + i), ref_mem[128 + i], 4'hf, resp);
			check_resp("shared write", mem_pkg::RESP_OKAY, resp);
			w = next_random();
			dm_write(word_addr(128 + i), w, 4'b0110, resp);
			check_resp("shared partial write", mem_pkg::RESP_OKAY, resp);
			ref_mem[128 + i] = merge_bytes(ref_mem[128 + i], w, 4'b0110);
			dm_read(word_addr(128 + i), w, resp);
			check_resp("shared read", mem_pkg::RESP_OKAY, resp);
			check_word("shared read", ref_mem[128 + i], w);
		end
		// alternating priority lets fetch in between data accesses
		if (fetch_pc.size() - n0 < 16) begin
			errors++;
			$display("shared: fetch made too little progress during data accesses");
		end
		// roughly one fetch per data access, so the program is still running
		if (finish !== 1'b0) begin
			errors++;
			$display("shared: data accesses held back until fetch had finished");
		end
		wait_stop();
		check_fetch("shared fetch", 97);
	endtask

	task automatic test_fetch_past_end();
		do_reset();
		load_program(MEM_WORDS, 1'b0);
		start_fetch();
		wait_stop();
		check_fetch("past_end", MEM_WORDS);
		if (invalid !== 1'b1 || finish !== 1'b0) begin
			errors++;
			$display("past_end: invalid not set or finish set after fetch past memory end");
		end
	endtask

	initial begin
		rst_n_i = 1'b0;
		fetch_en_i = 1'b0;
		dm_ar = '0;
		dm_ar_valid = 1'b0;
		dm_r_ready = 1'b1;
		dm_aw = '0;
		dm_aw_valid = 1'b0;
		dm_w = '0;
		dm_w_valid = 1'b0;
		dm_b_ready = 1'b1;
		@(negedge clk);
		do_reset();
		test_strobe_rw();
		test_out_of_range();
		test_fetch_finish();
		test_shared_access();
		test_fetch_past_end();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
rtl/mem_pkg.sv
rtl/fetch_unit.sv
rtl/axi_arbiter.sv
rtl/axi_sram.sv
rtl/core_top.sv
testbench/core_top_chk.sv
testbench/tb_core_top.sv

/* Makefile */
# Verilator build and run of the core_top testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module tb_core_top -Mdir obj_dir

run: compile
	./obj_dir/Vtb_core_top | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
